// File: Makefile
TOP = tb_ooo_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^>>> PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: compile.f
design/ooo_pkg.sv
design/stage_if.sv
design/rename_stage.sv
design/issue_stage.sv
design/exec_stage.sv
design/reorder_buffer.sv
design/ooo_core.sv
sim/tb_ooo_core.sv

// File: design/exec_stage.sv
// one-cycle ALU, pipelined multiplier and common data bus arbitration
`timescale 1ns/1ps

module exec_stage import ooo_pkg::*; #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48,
	parameter int ROB_DEPTH = 8
) (
	input  logic	clk,
	input  logic	arst_n,
	exec_if.sink	ex,
	cdb_if.source	cdb
);

	localparam int PRF_W = $clog2(PRF_DEPTH);
	localparam int ROB_W = $clog2(ROB_DEPTH);
	localparam int SH_W  = $clog2(DATA_W);

	logic [DATA_W-1:0]		result;
	logic					alu_start;
	logic					mul_start;
	logic					mul_out;			// last multiplier stage owns the bus
	logic					alu_valid;
	logic [DATA_W-1:0]		alu_value;
	logic [PRF_W-1:0]		alu_prn;
	logic [ROB_W-1:0]		alu_rob;
	logic					alu_wr;
	logic [MUL_LATENCY-1:0]	mul_valid;
	logic [MUL_LATENCY-1:0]	mul_wr;
	logic [DATA_W-1:0]		mul_value [MUL_LATENCY];
	logic [PRF_W-1:0]		mul_prn [MUL_LATENCY];
	logic [ROB_W-1:0]		mul_rob [MUL_LATENCY];

	always_comb begin
		case (ex.op)
			ALU_ADD: result = ex.opa + ex.opb;
			ALU_SUB: result = ex.opa - ex.opb;
			ALU_AND: result = ex.opa & ex.opb;
			ALU_OR:  result = ex.opa | ex.opb;
			ALU_XOR: result = ex.opa ^ ex.opb;
			ALU_SLL: result = ex.opa << ex.opb[SH_W-1:0];
			default: result = ex.opa * ex.opb;		// keeps the low DATA_W bits
		endcase
	end

	assign mul_out   = mul_valid[MUL_LATENCY-1];
	assign ex.ready  = !(alu_valid && mul_out);		// held ALU result blocks issue
	assign alu_start = ex.valid && ex.ready && ex.op != ALU_MULQ;
	assign mul_start = ex.valid && ex.ready && ex.op == ALU_MULQ;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_valid <= 1'b0;
			mul_valid <= '0;
		end else begin
			if (alu_start) begin
				alu_valid <= 1'b1;
			end else if (!mul_out) begin
				alu_valid <= 1'b0;			// sent this cycle
			end
			mul_valid <= {mul_valid[MUL_LATENCY-2:0], mul_start};
		end
	end

	always_ff @(posedge clk) begin
		if (alu_start) begin
			alu_value <= result;
			alu_prn   <= ex.prn;
			alu_rob   <= ex.rob_idx;
			alu_wr    <= ex.has_dest;
		end
		mul_value[0] <= result;			// stage 0 follows the inputs and valid gates it
		mul_prn[0]   <= ex.prn;
		mul_rob[0]   <= ex.rob_idx;
		mul_wr       <= {mul_wr[MUL_LATENCY-2:0], ex.has_dest};
		for (int i = 1; i < MUL_LATENCY; i++) begin
			mul_value[i] <= mul_value[i-1];
			mul_prn[i]   <= mul_prn[i-1];
			mul_rob[i]   <= mul_rob[i-1];
		end
	end

	////////////////////////////////////////
	// bus arbitration with the multiplier first
	assign cdb.valid   = mul_out || alu_valid;
	assign cdb.wr_en   = mul_out ? mul_wr[MUL_LATENCY-1] : alu_wr;
	assign cdb.prn     = mul_out ? mul_prn[MUL_LATENCY-1] : alu_prn;
	assign cdb.rob_idx = mul_out ? mul_rob[MUL_LATENCY-1] : alu_rob;
	assign cdb.value   = mul_out ? mul_value[MUL_LATENCY-1] : alu_value;

	a_alu_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
		alu_valid && mul_out |=> alu_valid && $stable(alu_value) && $stable(alu_rob))
		else $error("waiting ALU result overwritten");

endmodule

// File: design/issue_stage.sv
// physical register file with ready bits, issues the renamed head instruction in order
`timescale 1ns/1ps

module issue_stage import ooo_pkg::*; #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48
) (
	input  logic		clk,
	input  logic		arst_n,
	rename_if.sink		in,
	rob_alloc_if.source	rob,
	exec_if.source		ex,
	cdb_if.sink			cdb
);

	logic [DATA_W-1:0]		prf_value [PRF_DEPTH];
	logic [PRF_DEPTH-1:0]	prf_ready;
	logic					opa_ready;
	logic					opb_ready;
	logic					issue;

	assign opa_ready = prf_ready[in.opa_prn];
	assign opb_ready = in.opb_is_imm || prf_ready[in.opb_prn];		// imm always ready

	// all three transfers fire on the same edge
	assign in.ready = opa_ready && opb_ready && rob.ready && ex.ready;
	assign issue    = in.valid && in.ready;

	assign rob.valid    = in.valid && opa_ready && opb_ready && ex.ready;
	assign rob.dest_arn = in.dest_arn;
	assign rob.prev_prn = in.prev_prn;
	assign rob.has_dest = in.has_dest;

	assign ex.valid    = in.valid && opa_ready && opb_ready && rob.ready;
	assign ex.op       = in.op;
	assign ex.opa      = prf_value[in.opa_prn];
	assign ex.opb      = in.opb_is_imm ? DATA_W'(in.imm) : prf_value[in.opb_prn];
	assign ex.has_dest = in.has_dest;
	assign ex.prn      = in.dest_prn;
	assign ex.rob_idx  = rob.idx;			// tail slot goes along with the op

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prf_ready <= '1;
			for (int i = 0; i < PRF_DEPTH; i++) begin
				prf_value[i] <= '0;			// register 31 stays zero from here
			end
		end else begin
			if (issue && in.has_dest) begin
				prf_ready[in.dest_prn] <= 1'b0;		// pending result
			end
			if (cdb.valid && cdb.wr_en) begin
				prf_ready[cdb.prn] <= 1'b1;
				prf_value[cdb.prn] <= cdb.value;
			end
		end
	end

	// a source read at issue is not still being produced on the bus
	a_issue_operands_ready: assert property (@(posedge clk) disable iff (!arst_n)
		issue && cdb.valid && cdb.wr_en |-> cdb.prn != in.opa_prn &&
		(in.opb_is_imm || cdb.prn != in.opb_prn))
		else $error("issue with a source not ready");

endmodule

// File: design/ooo_core.sv
// integer back end top level, links rename, issue, execute and reorder stages
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48,		// more than ARF_SIZE
	parameter int ROB_DEPTH = 8			// power of two
) (
	input  logic				clk,
	input  logic				arst_n,
	input  logic				inst_req,
	input  alu_op_e				inst_op,
	input  arn_t				inst_dest,
	input  arn_t				inst_opa,
	input  arn_t				inst_opb,
	input  logic				inst_opb_is_imm,
	input  logic [IMM_W-1:0]	inst_imm,
	output logic				inst_ack,
	output logic				commit_valid,
	output arn_t				commit_dest,
	output logic [DATA_W-1:0]	commit_value
);

	logic							free_valid;
	logic [$clog2(PRF_DEPTH)-1:0]	free_prn;

	rename_if #(.PRF_DEPTH(PRF_DEPTH)) rename_link ();
	rob_alloc_if #(.PRF_DEPTH(PRF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) alloc_link ();
	exec_if #(.DATA_W(DATA_W), .PRF_DEPTH(PRF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) exec_link ();
	cdb_if #(.DATA_W(DATA_W), .PRF_DEPTH(PRF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) cdb ();

	////////////////////////////////////////
	// front end with rename and issue
	rename_stage #(.PRF_DEPTH(PRF_DEPTH)) rename_i (
		.clk(clk),
		.arst_n(arst_n),
		.inst_req(inst_req),
		.inst_op(inst_op),
		.inst_dest(inst_dest),
		.inst_opa(inst_opa),
		.inst_opb(inst_opb),
		.inst_opb_is_imm(inst_opb_is_imm),
		.inst_imm(inst_imm),
		.inst_ack(inst_ack),
		.out(rename_link.source),
		.free_valid(free_valid),			// reclaim path from commit
		.free_prn(free_prn)
	);

	issue_stage #(.DATA_W(DATA_W), .PRF_DEPTH(PRF_DEPTH)) issue_i (
		.clk(clk),
		.arst_n(arst_n),
		.in(rename_link.sink),
		.rob(alloc_link.source),
		.ex(exec_link.source),
		.cdb(cdb.sink)
	);

	////////////////////////////////////////
	// back end with execute and commit
	exec_stage #(.DATA_W(DATA_W), .PRF_DEPTH(PRF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) exec_i (
		.clk(clk),
		.arst_n(arst_n),
		.ex(exec_link.sink),
		.cdb(cdb.source)
	);

	reorder_buffer #(.DATA_W(DATA_W), .PRF_DEPTH(PRF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) rob_i (
		.clk(clk),
		.arst_n(arst_n),
		.alloc(alloc_link.sink),
		.cdb(cdb.sink),
		.free_valid(free_valid),
		.free_prn(free_prn),
		.commit_valid(commit_valid),
		.commit_dest(commit_dest),
		.commit_value(commit_value)
	);

endmodule

// File: design/ooo_pkg.sv
// shared constants, register index type and opcode encoding for the integer back end
package ooo_pkg;

	localparam int ARF_SIZE    = 32;	// architectural registers
	localparam int ZERO_REG    = 31;	// reads zero, never renamed
	localparam int IMM_W       = 8;		// literal operand, zero-extended
	localparam int MUL_LATENCY = 3;		// multiplier pipe depth

	typedef logic [4:0] arn_t;		// architectural register index

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,		// shift by low bits of opb
		ALU_MULQ		// low half of the product, goes to the multiplier
	} alu_op_e;

endpackage

// File: design/rename_stage.sv
// register rename with map table, FIFO free list and the four-phase instruction handshake
`timescale 1ns/1ps

module rename_stage import ooo_pkg::*; #(
	parameter int PRF_DEPTH = 48
) (
	input  logic							clk,
	input  logic							arst_n,
	input  logic							inst_req,
	input  alu_op_e							inst_op,
	input  arn_t							inst_dest,
	input  arn_t							inst_opa,
	input  arn_t							inst_opb,
	input  logic							inst_opb_is_imm,
	input  logic [IMM_W-1:0]				inst_imm,
	output logic							inst_ack,
	rename_if.source						out,
	input  logic							free_valid,		// reclaimed by the ROB
	input  logic [$clog2(PRF_DEPTH)-1:0]	free_prn
);

	localparam int PRF_W    = $clog2(PRF_DEPTH);
	localparam int FL_DEPTH = PRF_DEPTH - ARF_SIZE;	// spare registers
	localparam int FL_W     = $clog2(FL_DEPTH);
	localparam int CNT_W    = $clog2(FL_DEPTH + 1);

	logic [PRF_W-1:0]	map_table [ARF_SIZE];
	logic [PRF_W-1:0]	fl_mem [FL_DEPTH];
	logic [FL_W-1:0]	fl_rd_ptr;
	logic [FL_W-1:0]	fl_wr_ptr;
	logic [CNT_W-1:0]	fl_count;
	logic				need_dest;
	logic				accept;
	logic				fl_pop;

	assign need_dest = inst_dest != arn_t'(ZERO_REG);
	assign accept    = inst_req && !inst_ack && (!out.valid || out.ready) &&
		(!need_dest || fl_count != '0);
	assign fl_pop    = accept && need_dest;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				map_table[i] <= PRF_W'(i);		// identity mapping
			end
		end else if (fl_pop) begin
			map_table[inst_dest] <= fl_mem[fl_rd_ptr];
		end
	end

	////////////////////////////////////////
	// free list
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_mem[i] <= PRF_W'(ARF_SIZE + i);	// spares start full
			end
			fl_rd_ptr <= '0;
			fl_wr_ptr <= '0;
			fl_count  <= CNT_W'(FL_DEPTH);
		end else begin
			if (free_valid) begin
				fl_mem[fl_wr_ptr] <= free_prn;
				fl_wr_ptr <= (fl_wr_ptr == FL_W'(FL_DEPTH - 1)) ? '0 : fl_wr_ptr + 1'b1;
			end
			if (fl_pop) begin
				fl_rd_ptr <= (fl_rd_ptr == FL_W'(FL_DEPTH - 1)) ? '0 : fl_rd_ptr + 1'b1;
			end
			fl_count <= fl_count + CNT_W'(free_valid) - CNT_W'(fl_pop);
		end
	end

	////////////////////////////////////////
	// handshake and output slot
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out.valid <= 1'b0;
			inst_ack  <= 1'b0;
		end else begin
			if (accept) begin
				out.valid <= 1'b1;
			end else if (out.ready) begin
				out.valid <= 1'b0;				// taken by issue
			end
			if (accept) begin
				inst_ack <= 1'b1;
			end else if (!inst_req) begin
				inst_ack <= 1'b0;				// req dropped so the cycle closes
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out.op         <= inst_op;
			out.opa_prn    <= map_table[inst_opa];
			out.opb_prn    <= map_table[inst_opb];
			out.opb_is_imm <= inst_opb_is_imm;
			out.imm        <= inst_imm;
			out.dest_arn   <= inst_dest;
			out.dest_prn   <= need_dest ? fl_mem[fl_rd_ptr] : map_table[inst_dest];
			out.prev_prn   <= map_table[inst_dest];		// freed when this commits
			out.has_dest   <= need_dest;
		end
	end

	// equal pointers mean empty unless the count says full
	a_fl_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		fl_pop |-> fl_rd_ptr != fl_wr_ptr || fl_count == CNT_W'(FL_DEPTH))
		else $error("free list pop while empty");

endmodule

// File: design/reorder_buffer.sv
// circular reorder buffer, completes from the bus and commits in program order
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48,
	parameter int ROB_DEPTH = 8
) (
	input  logic							clk,
	input  logic							arst_n,
	rob_alloc_if.sink						alloc,
	cdb_if.sink								cdb,
	output logic							free_valid,
	output logic [$clog2(PRF_DEPTH)-1:0]	free_prn,
	output logic							commit_valid,
	output arn_t							commit_dest,
	output logic [DATA_W-1:0]				commit_value
);

	localparam int PRF_W = $clog2(PRF_DEPTH);
	localparam int ROB_W = $clog2(ROB_DEPTH);

	logic [ROB_DEPTH-1:0]	busy;				// entry allocated
	logic [ROB_DEPTH-1:0]	done;				// result arrived
	logic [ROB_DEPTH-1:0]	has_dest;
	arn_t					dest_arn [ROB_DEPTH];
	logic [PRF_W-1:0]		prev_prn [ROB_DEPTH];
	logic [DATA_W-1:0]		value [ROB_DEPTH];
	logic [ROB_W-1:0]		head;
	logic [ROB_W-1:0]		tail;
	logic					do_alloc;
	logic					do_commit;

	assign alloc.ready = !busy[tail];			// full when tail meets a live entry
	assign alloc.idx   = tail;
	assign do_alloc    = alloc.valid && alloc.ready;
	assign do_commit   = busy[head] && done[head];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy         <= '0;
			done         <= '0;
			head         <= '0;
			tail         <= '0;
			commit_valid <= 1'b0;
			free_valid   <= 1'b0;
		end else begin
			if (do_alloc) begin
				busy[tail] <= 1'b1;
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;		// power-of-two wrap
			end
			if (cdb.valid) begin
				done[cdb.rob_idx] <= 1'b1;
			end
			if (do_commit) begin
				busy[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			commit_valid <= do_commit;
			free_valid   <= do_commit && has_dest[head];	// zero-reg writes free nothing
		end
	end

	always_ff @(posedge clk) begin
		if (do_alloc) begin
			dest_arn[tail] <= alloc.dest_arn;
			prev_prn[tail] <= alloc.prev_prn;
			has_dest[tail] <= alloc.has_dest;
		end
		if (cdb.valid) begin
			value[cdb.rob_idx] <= cdb.value;
		end
		if (do_commit) begin
			commit_dest  <= dest_arn[head];
			commit_value <= value[head];
			free_prn     <= prev_prn[head];
		end
	end

	a_cdb_hits_live_entry: assert property (@(posedge clk) disable iff (!arst_n)
		cdb.valid |-> busy[cdb.rob_idx] && !done[cdb.rob_idx])
		else $error("bus result for an entry not waiting on it");

endmodule

// File: design/stage_if.sv
// valid/ready links between the rename, issue, execute and reorder stages
`timescale 1ns/1ps

interface rename_if import ooo_pkg::*; #(
	parameter int PRF_DEPTH = 48
) ();
	localparam int PRF_W = $clog2(PRF_DEPTH);

	logic				valid;
	logic				ready;
	alu_op_e			op;
	logic [PRF_W-1:0]	opa_prn;
	logic [PRF_W-1:0]	opb_prn;
	logic				opb_is_imm;		// opb comes from imm
	logic [IMM_W-1:0]	imm;
	arn_t				dest_arn;
	logic [PRF_W-1:0]	dest_prn;
	logic [PRF_W-1:0]	prev_prn;		// mapping that dest replaces
	logic				has_dest;		// dest is not the zero register

	modport source (output valid, op, opa_prn, opb_prn, opb_is_imm, imm, dest_arn,
		dest_prn, prev_prn, has_dest, input ready);
	modport sink (input valid, op, opa_prn, opb_prn, opb_is_imm, imm, dest_arn,
		dest_prn, prev_prn, has_dest, output ready);
endinterface

interface rob_alloc_if import ooo_pkg::*; #(
	parameter int PRF_DEPTH = 48,
	parameter int ROB_DEPTH = 8
) ();
	logic							valid;
	logic							ready;		// a slot is free
	logic [$clog2(ROB_DEPTH)-1:0]	idx;		// tail slot, driven by the ROB
	arn_t							dest_arn;
	logic [$clog2(PRF_DEPTH)-1:0]	prev_prn;
	logic							has_dest;

	modport source (output valid, dest_arn, prev_prn, has_dest, input ready, idx);
	modport sink (input valid, dest_arn, prev_prn, has_dest, output ready, idx);
endinterface

interface exec_if import ooo_pkg::*; #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48,
	parameter int ROB_DEPTH = 8
) ();
	logic							valid;
	logic							ready;
	alu_op_e						op;
	logic [DATA_W-1:0]				opa;
	logic [DATA_W-1:0]				opb;
	logic							has_dest;
	logic [$clog2(PRF_DEPTH)-1:0]	prn;
	logic [$clog2(ROB_DEPTH)-1:0]	rob_idx;

	modport source (output valid, op, opa, opb, has_dest, prn, rob_idx, input ready);
	modport sink (input valid, op, opa, opb, has_dest, prn, rob_idx, output ready);
endinterface

// common data bus, no back-pressure
interface cdb_if #(
	parameter int DATA_W    = 64,
	parameter int PRF_DEPTH = 48,
	parameter int ROB_DEPTH = 8
) ();
	logic							valid;
	logic							wr_en;		// write the PRF as well
	logic [$clog2(PRF_DEPTH)-1:0]	prn;
	logic [$clog2(ROB_DEPTH)-1:0]	rob_idx;
	logic [DATA_W-1:0]				value;

	modport source (output valid, wr_en, prn, rob_idx, value);
	modport sink (input valid, wr_en, prn, rob_idx, value);
endinterface

// File: sim/tb_ooo_core.sv
// testbench for the integer back end with a golden register model and in-order commit checks
`timescale 1ns/1ps

module tb_ooo_core import ooo_pkg::*; ();

	localparam int DATA_W       = 64;
	localparam int WAIT_LIMIT   = 200;	// cycles per wait loop
	localparam int RANDOM_COUNT = 300;

	logic				clk = 1'b0;
	logic				arst_n;
	logic				inst_req;
	alu_op_e			inst_op;
	arn_t				inst_dest;
	arn_t				inst_opa;
	arn_t				inst_opb;
	logic				inst_opb_is_imm;
	logic [IMM_W-1:0]	inst_imm;
	logic				inst_ack;
	logic				commit_valid;
	arn_t				commit_dest;
	logic [DATA_W-1:0]	commit_value;

	logic [DATA_W-1:0]	arf [ARF_SIZE];		// architectural state in program order
	arn_t				exp_dest [$];
	logic [DATA_W-1:0]	exp_value [$];
	arn_t				want_dest;
	logic [DATA_W-1:0]	want_value;
	int					errors;
	int					req_count;
	int					commit_count;
	int					drain_wait;
	int					seed;
	int unsigned		rnd_op;

	always #2 clk = ~clk;				// 4 ns period

	ooo_core #(.DATA_W(DATA_W), .PRF_DEPTH(48), .ROB_DEPTH(8)) dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.inst_req(inst_req),
		.inst_op(inst_op),
		.inst_dest(inst_dest),
		.inst_opa(inst_opa),
		.inst_opb(inst_opb),
		.inst_opb_is_imm(inst_opb_is_imm),
		.inst_imm(inst_imm),
		.inst_ack(inst_ack),
		.commit_valid(commit_valid),
		.commit_dest(commit_dest),
		.commit_value(commit_value)
	);

	task automatic flag_error(input string msg);
		errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("errors %0d, requests %0d, commits %0d", errors, req_count, commit_count);
		$display(">>> FAIL");
		$finish;
	endtask

	// reference result with 64-bit wrap, a 6-bit shift amount and the low half of the product
	function automatic logic [DATA_W-1:0] alu_result(input alu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [2*DATA_W-1:0] product;
		product = a * b;
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[5:0];
			default: return product[DATA_W-1:0];
		endcase
	endfunction

	task automatic check_idle(input string when_txt);
		a_idle_ack: assert (!inst_ack) else flag_error({"inst_ack high ", when_txt});
		a_idle_commit: assert (!commit_valid) else flag_error({"commit_valid high ", when_txt});
	endtask

	////////////////////////////////////////
	// one instruction through the four-phase handshake
	task automatic send_inst(input alu_op_e op, input arn_t dest, input arn_t opa,
		input arn_t opb, input logic opb_is_imm, input logic [IMM_W-1:0] imm);
		logic [DATA_W-1:0]	b;
		logic [DATA_W-1:0]	result;
		int					waited;
		b      = opb_is_imm ? DATA_W'(imm) : arf[opb];
		result = alu_result(op, arf[opa], b);
		exp_dest.push_back(dest);
		exp_value.push_back(result);
		if (dest != arn_t'(ZERO_REG)) begin
			arf[dest] = result;				// register 31 keeps reading zero
		end
		@(posedge clk);
		inst_req        <= 1'b1;
		inst_op         <= op;
		inst_dest       <= dest;
		inst_opa        <= opa;
		inst_opb        <= opb;
		inst_opb_is_imm <= opb_is_imm;
		inst_imm        <= imm;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_on_timeout("inst_ack to rise");
			end
		end while (!inst_ack);
		req_count++;
		@(posedge clk);
		inst_req <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_on_timeout("inst_ack to fall");
			end
		end while (inst_ack);
	endtask

	////////////////////////////////////////
	// handshake and commit checks
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		!inst_req && !inst_ack |=> !inst_ack)
		else flag_error("inst_ack rose while inst_req was low");

	a_ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
		inst_ack && !inst_req |=> !inst_ack)
		else flag_error("inst_ack stayed high after inst_req fell");

	always @(negedge clk) begin
		if (arst_n && commit_valid) begin
			commit_count++;
			if (exp_dest.size() == 0) begin
				flag_error("commit with no instruction outstanding");
			end else begin
				want_dest  = exp_dest.pop_front();		// oldest first
				want_value = exp_value.pop_front();
				a_commit_dest: assert (commit_dest == want_dest)
					else flag_error($sformatf("commit_dest %0d, expected %0d",
						commit_dest, want_dest));
				a_commit_value: assert (commit_value == want_value)
					else flag_error($sformatf("commit_value %h, expected %h (dest %0d)",
						commit_value, want_value, want_dest));
			end
		end
	end

	initial begin
		seed         = 93750;
		errors       = 0;
		req_count    = 0;
		commit_count = 0;
		for (int i = 0; i < ARF_SIZE; i++) begin
			arf[i] = '0;
		end
		arst_n          <= 1'b0;
		inst_req        <= 1'b0;
		inst_op         <= ALU_ADD;
		inst_dest       <= '0;
		inst_opa        <= '0;
		inst_opb        <= '0;
		inst_opb_is_imm <= 1'b0;
		inst_imm        <= '0;
		repeat (4) begin
			@(negedge clk);
			check_idle("during reset");
		end
		@(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_idle("in the first cycle after reset");

		// load registers 1..8 from immediates
		for (int r = 1; r <= 8; r++) begin
			send_inst(ALU_ADD, arn_t'(r), 5'd31, 5'd31, 1'b1, IMM_W'(r * 29 + 7));
		end
		send_inst(ALU_SUB, 5'd9, 5'd1, 5'd2, 1'b0, 8'h00);	// goes negative
		send_inst(ALU_AND, 5'd10, 5'd3, 5'd4, 1'b0, 8'h00);
		send_inst(ALU_OR, 5'd11, 5'd5, 5'd0, 1'b1, 8'ha5);
		send_inst(ALU_XOR, 5'd12, 5'd6, 5'd0, 1'b1, 8'h3c);
		send_inst(ALU_SLL, 5'd13, 5'd7, 5'd0, 1'b1, 8'd60);
		send_inst(ALU_SLL, 5'd14, 5'd8, 5'd2, 1'b0, 8'h00);	// shift by low bits of r2
		send_inst(ALU_MULQ, 5'd15, 5'd1, 5'd2, 1'b0, 8'h00);
		send_inst(ALU_MULQ, 5'd16, 5'd3, 5'd0, 1'b1, 8'd200);

		// dependent chain where a multiply feeds an add right away
		send_inst(ALU_MULQ, 5'd17, 5'd15, 5'd15, 1'b0, 8'h00);
		send_inst(ALU_ADD, 5'd18, 5'd17, 5'd0, 1'b1, 8'd1);
		send_inst(ALU_MULQ, 5'd19, 5'd18, 5'd9, 1'b0, 8'h00);
		send_inst(ALU_XOR, 5'd20, 5'd1, 5'd2, 1'b0, 8'h00);	// independent of the multiply
		send_inst(ALU_ADD, 5'd21, 5'd19, 5'd20, 1'b0, 8'h00);

		// writes to the zero register commit but reads stay zero
		send_inst(ALU_ADD, 5'd31, 5'd1, 5'd0, 1'b1, 8'd9);
		send_inst(ALU_ADD, 5'd22, 5'd31, 5'd0, 1'b1, 8'd2);
		send_inst(ALU_OR, 5'd23, 5'd31, 5'd31, 1'b0, 8'h00);
		send_inst(ALU_MULQ, 5'd31, 5'd4, 5'd5, 1'b0, 8'h00);
		send_inst(ALU_SUB, 5'd24, 5'd31, 5'd1, 1'b0, 8'h00);

		// random mix of far more instructions than spare physical registers
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			rnd_op = $unsigned($random(seed)) % 7;
			send_inst(alu_op_e'(rnd_op), arn_t'($random(seed)), arn_t'($random(seed)),
				arn_t'($random(seed)), 1'($random(seed)), IMM_W'($random(seed)));
		end

		drain_wait = 0;
		while (commit_count != req_count) begin
			@(posedge clk);
			drain_wait++;
			if (drain_wait > WAIT_LIMIT) begin
				abort_on_timeout("the last commits");
			end
		end
		a_all_committed: assert (exp_dest.size() == 0)
			else flag_error("expected commits left over after the last commit");

		$display("errors %0d, requests %0d, commits %0d", errors, req_count, commit_count);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
